// File: source/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // ########################################################################
    // widths and depths.
    // ########################################################################

    // one 32-bit word for both addresses and data.
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // operand slots handed to execute.
    localparam int NUM_OPS = 4;

    // scratch memory geometry.
    localparam int MEM_DEPTH = 64;
    // word index sits in address bits 7:2.
    localparam int MEM_IDX_W = 6;

    // apb byte address; 256 and up is out of range.
    localparam int APB_ADDR_W = 10;

    // string ops step by one word.
    localparam int WORD_BYTES = 4;

    // ########################################################################
    // encodings.
    // ########################################################################

    // operand source select, one per lane.
    typedef enum logic [2:0] {
        SRC_REG1 = 3'd0,
        SRC_REG2 = 3'd1,
        SRC_REG3 = 3'd2,
        SRC_REG4 = 3'd3,
        SRC_MEM1 = 3'd4,
        SRC_MEM2 = 3'd5,
        SRC_IMM  = 3'd6,
        SRC_EIP  = 3'd7
    } op_src_e;

    // address generator stepping state.
    typedef enum logic [0:0] {
        AG_IDLE = 1'b0,
        AG_REP  = 1'b1
    } agen_state_e;

endpackage

`default_nettype wire

// File: source/mem_agen.sv
`timescale 1ns/1ps
`default_nettype none

module mem_agen (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       valid_i,
    input  logic                       is_rep_i,
    input  logic                       dir_i,
    input  logic [mem_pkg::ADDR_W-1:0] rep_cnt_i,
    input  logic [mem_pkg::ADDR_W-1:0] mem_addr1_i,
    input  logic [mem_pkg::ADDR_W-1:0] mem_addr2_i,
    input  logic                       hold_i,
    output logic [mem_pkg::ADDR_W-1:0] addr1_o,
    output logic [mem_pkg::ADDR_W-1:0] addr2_o,
    output logic                       beat_o,
    output logic                       stall_o
);
    import mem_pkg::*;

    agen_state_e       state_q;
    logic [ADDR_W-1:0] cnt_q;
    logic [ADDR_W-1:0] addr1_q;
    logic [ADDR_W-1:0] addr2_q;
    logic              dir_q;
    logic [ADDR_W-1:0] step_in;
    logic [ADDR_W-1:0] step_rep;
    logic              cnt_zero;
    logic              cnt_multi;
    logic              rep_start;
    logic              rep_step;

    assign step_in  = dir_i ? ADDR_W'(-WORD_BYTES) : ADDR_W'(WORD_BYTES);
    assign step_rep = dir_q ? ADDR_W'(-WORD_BYTES) : ADDR_W'(WORD_BYTES);

    assign cnt_zero  = (rep_cnt_i == '0);
    assign cnt_multi = (rep_cnt_i > ADDR_W'(1));

    // first beat of a longer rep goes out while still idle.
    assign rep_start = (state_q == AG_IDLE) && valid_i && is_rep_i && cnt_multi && !hold_i;
    assign rep_step  = (state_q == AG_REP) && !hold_i;

    always_comb begin
        if (state_q == AG_IDLE) begin
            addr1_o = mem_addr1_i;
            addr2_o = mem_addr2_i;
            beat_o  = valid_i && !(is_rep_i && cnt_zero) && !hold_i;
            stall_o = hold_i || (valid_i && is_rep_i && cnt_multi);
        end else begin
            addr1_o = addr1_q;
            addr2_o = addr2_q;
            beat_o  = !hold_i;
            // drops in the cycle that issues the last beat.
            stall_o = hold_i || (cnt_q != ADDR_W'(1));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= AG_IDLE;
            cnt_q   <= '0;
        end else if (rep_start) begin
            state_q <= AG_REP;
            cnt_q   <= rep_cnt_i - ADDR_W'(1);
        end else if (rep_step) begin
            cnt_q <= cnt_q - ADDR_W'(1);
            if (cnt_q == ADDR_W'(1)) begin
                state_q <= AG_IDLE;
            end
        end
    end

    // next-beat addresses, advanced once per issued beat.
    always_ff @(posedge clk) begin
        if (rep_start) begin
            addr1_q <= mem_addr1_i + step_in;
            addr2_q <= mem_addr2_i + step_in;
            dir_q   <= dir_i;
        end else if (rep_step) begin
            addr1_q <= addr1_q + step_rep;
            addr2_q <= addr2_q + step_rep;
        end
    end

endmodule

`default_nettype wire

// File: source/mem_scratch.sv
`timescale 1ns/1ps
`default_nettype none

module mem_scratch (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           psel_i,
    input  logic                           penable_i,
    input  logic                           pwrite_i,
    input  logic [mem_pkg::APB_ADDR_W-1:0] paddr_i,
    input  logic [mem_pkg::DATA_W-1:0]     pwdata_i,
    output logic [mem_pkg::DATA_W-1:0]     prdata_o,
    output logic                           pready_o,
    output logic                           pslverr_o,
    input  logic [mem_pkg::ADDR_W-1:0]     rd_addr1_i,
    input  logic [mem_pkg::ADDR_W-1:0]     rd_addr2_i,
    output logic [mem_pkg::DATA_W-1:0]     rd_data1_o,
    output logic [mem_pkg::DATA_W-1:0]     rd_data2_o
);
    import mem_pkg::*;

    logic [DATA_W-1:0]    mem_q [MEM_DEPTH];
    logic [MEM_IDX_W-1:0] apb_idx;
    logic                 apb_oor;
    logic                 apb_setup;
    logic                 apb_access;
    logic [DATA_W-1:0]    prdata_q;
    logic                 pready_q;
    logic                 pslverr_q;

    // ########################################################################
    // apb side.
    // ########################################################################

    assign apb_idx    = paddr_i[MEM_IDX_W+1:2];
    assign apb_oor    = (paddr_i[APB_ADDR_W-1:MEM_IDX_W+2] != '0);
    assign apb_setup  = psel_i && !penable_i;
    assign apb_access = psel_i && penable_i;

    // response is set up during the setup phase and shown in the access phase.
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pready_q  <= 1'b0;
            pslverr_q <= 1'b0;
        end else begin
            pready_q  <= apb_setup;
            pslverr_q <= apb_setup && apb_oor;
        end
    end

    always_ff @(posedge clk) begin
        if (apb_setup) begin
            prdata_q <= (!pwrite_i && !apb_oor) ? mem_q[apb_idx] : '0;
        end
    end

    // writes land at the access edge; out of range ones are dropped.
    always_ff @(posedge clk) begin
        if (apb_access && pwrite_i && !apb_oor) begin
            mem_q[apb_idx] <= pwdata_i;
        end
    end

    assign prdata_o  = prdata_q;
    assign pready_o  = pready_q;
    assign pslverr_o = pslverr_q;

    // ########################################################################
    // operand read ports.
    // ########################################################################

    assign rd_data1_o = mem_q[rd_addr1_i[MEM_IDX_W+1:2]];
    assign rd_data2_o = mem_q[rd_addr2_i[MEM_IDX_W+1:2]];

endmodule

`default_nettype wire

// File: source/op_lane.sv
`timescale 1ns/1ps
`default_nettype none

module op_lane (
    input  mem_pkg::op_src_e             sel_i,
    input  logic [4*mem_pkg::DATA_W-1:0] regs_i,
    input  logic [mem_pkg::DATA_W-1:0]   mem1_i,
    input  logic [mem_pkg::DATA_W-1:0]   mem2_i,
    input  logic [mem_pkg::DATA_W-1:0]   imm_i,
    input  logic [mem_pkg::DATA_W-1:0]   eip_i,
    output logic [mem_pkg::DATA_W-1:0]   op_o
);
    import mem_pkg::*;

    logic [DATA_W-1:0] reg1;
    logic [DATA_W-1:0] reg2;
    logic [DATA_W-1:0] reg3;
    logic [DATA_W-1:0] reg4;

    // reg1 is the lowest word.
    assign reg1 = regs_i[0*DATA_W +: DATA_W];
    assign reg2 = regs_i[1*DATA_W +: DATA_W];
    assign reg3 = regs_i[2*DATA_W +: DATA_W];
    assign reg4 = regs_i[3*DATA_W +: DATA_W];

    always_comb begin
        unique case (sel_i)
            SRC_REG1: begin
                op_o = reg1;
            end
            SRC_REG2: begin
                op_o = reg2;
            end
            SRC_REG3: begin
                op_o = reg3;
            end
            SRC_REG4: begin
                op_o = reg4;
            end
            SRC_MEM1: begin
                op_o = mem1_i;
            end
            SRC_MEM2: begin
                op_o = mem2_i;
            end
            SRC_IMM: begin
                op_o = imm_i;
            end
            default: begin
                op_o = eip_i;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/mem_latch.sv
`timescale 1ns/1ps
`default_nettype none

module mem_latch (
    input  logic                                     clk,
    input  logic                                     rst_n_i,
    input  logic                                     beat_i,
    input  logic [mem_pkg::NUM_OPS*mem_pkg::DATA_W-1:0] ops_i,
    input  logic [mem_pkg::ADDR_W-1:0]               addr1_i,
    input  logic [mem_pkg::ADDR_W-1:0]               addr2_i,
    input  logic                                     ready_i,
    output logic                                     hold_o,
    output logic                                     valid_o,
    output logic [mem_pkg::NUM_OPS*mem_pkg::DATA_W-1:0] ops_o,
    output logic [mem_pkg::ADDR_W-1:0]               addr1_o,
    output logic [mem_pkg::ADDR_W-1:0]               addr2_o
);
    import mem_pkg::*;

    logic                      valid_q;
    logic [NUM_OPS*DATA_W-1:0] ops_q;
    logic [ADDR_W-1:0]         addr1_q;
    logic [ADDR_W-1:0]         addr2_q;
    logic                      load;

    // a held beat that is not being taken blocks the next one.
    assign hold_o = valid_q && !ready_i;

    // loads when empty or draining this cycle.
    assign load = beat_i && !hold_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            ops_q   <= ops_i;
            addr1_q <= addr1_i;
            addr2_q <= addr2_i;
        end
    end

    assign valid_o = valid_q;
    assign ops_o   = ops_q;
    assign addr1_o = addr1_q;
    assign addr2_o = addr2_q;

endmodule

`default_nettype wire

// File: source/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           valid_i,
    input  logic                           is_rep_i,
    input  logic                           dir_i,
    input  logic [mem_pkg::ADDR_W-1:0]     rep_cnt_i,
    input  logic [mem_pkg::ADDR_W-1:0]     mem_addr1_i,
    input  logic [mem_pkg::ADDR_W-1:0]     mem_addr2_i,
    input  logic [mem_pkg::DATA_W-1:0]     reg1_i,
    input  logic [mem_pkg::DATA_W-1:0]     reg2_i,
    input  logic [mem_pkg::DATA_W-1:0]     reg3_i,
    input  logic [mem_pkg::DATA_W-1:0]     reg4_i,
    input  logic [mem_pkg::DATA_W-1:0]     imm_i,
    input  logic [mem_pkg::DATA_W-1:0]     eip_i,
    input  mem_pkg::op_src_e               op1_sel_i,
    input  mem_pkg::op_src_e               op2_sel_i,
    input  mem_pkg::op_src_e               op3_sel_i,
    input  mem_pkg::op_src_e               op4_sel_i,
    output logic                           stall_o,
    input  logic                           ready_i,
    output logic                           valid_o,
    output logic [mem_pkg::DATA_W-1:0]     op1_o,
    output logic [mem_pkg::DATA_W-1:0]     op2_o,
    output logic [mem_pkg::DATA_W-1:0]     op3_o,
    output logic [mem_pkg::DATA_W-1:0]     op4_o,
    output logic [mem_pkg::ADDR_W-1:0]     addr1_o,
    output logic [mem_pkg::ADDR_W-1:0]     addr2_o,
    input  logic                           psel_i,
    input  logic                           penable_i,
    input  logic                           pwrite_i,
    input  logic [mem_pkg::APB_ADDR_W-1:0] paddr_i,
    input  logic [mem_pkg::DATA_W-1:0]     pwdata_i,
    output logic [mem_pkg::DATA_W-1:0]     prdata_o,
    output logic                           pready_o,
    output logic                           pslverr_o
);
    import mem_pkg::*;

    op_src_e                   sel_w [NUM_OPS];
    logic [4*DATA_W-1:0]       regs_w;
    logic [ADDR_W-1:0]         agen_addr1;
    logic [ADDR_W-1:0]         agen_addr2;
    logic [DATA_W-1:0]         mem1_w;
    logic [DATA_W-1:0]         mem2_w;
    logic [NUM_OPS*DATA_W-1:0] ops_w;
    logic [NUM_OPS*DATA_W-1:0] ops_q;
    logic                      beat;
    logic                      hold;

    assign sel_w[0] = op1_sel_i;
    assign sel_w[1] = op2_sel_i;
    assign sel_w[2] = op3_sel_i;
    assign sel_w[3] = op4_sel_i;

    assign regs_w = {reg4_i, reg3_i, reg2_i, reg1_i};

    mem_agen u_agen (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .valid_i     (valid_i),
        .is_rep_i    (is_rep_i),
        .dir_i       (dir_i),
        .rep_cnt_i   (rep_cnt_i),
        .mem_addr1_i (mem_addr1_i),
        .mem_addr2_i (mem_addr2_i),
        .hold_i      (hold),
        .addr1_o     (agen_addr1),
        .addr2_o     (agen_addr2),
        .beat_o      (beat),
        .stall_o     (stall_o)
    );

    mem_scratch u_scratch (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .psel_i     (psel_i),
        .penable_i  (penable_i),
        .pwrite_i   (pwrite_i),
        .paddr_i    (paddr_i),
        .pwdata_i   (pwdata_i),
        .prdata_o   (prdata_o),
        .pready_o   (pready_o),
        .pslverr_o  (pslverr_o),
        .rd_addr1_i (agen_addr1),
        .rd_addr2_i (agen_addr2),
        .rd_data1_o (mem1_w),
        .rd_data2_o (mem2_w)
    );

    // one select lane per operand slot.
    for (genvar i = 0; i < NUM_OPS; i++) begin : g_lane
        op_lane u_lane (
            .sel_i  (sel_w[i]),
            .regs_i (regs_w),
            .mem1_i (mem1_w),
            .mem2_i (mem2_w),
            .imm_i  (imm_i),
            .eip_i  (eip_i),
            .op_o   (ops_w[i*DATA_W +: DATA_W])
        );
    end

    mem_latch u_latch (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .beat_i  (beat),
        .ops_i   (ops_w),
        .addr1_i (agen_addr1),
        .addr2_i (agen_addr2),
        .ready_i (ready_i),
        .hold_o  (hold),
        .valid_o (valid_o),
        .ops_o   (ops_q),
        .addr1_o (addr1_o),
        .addr2_o (addr2_o)
    );

    assign op1_o = ops_q[0*DATA_W +: DATA_W];
    assign op2_o = ops_q[1*DATA_W +: DATA_W];
    assign op3_o = ops_q[2*DATA_W +: DATA_W];
    assign op4_o = ops_q[3*DATA_W +: DATA_W];

endmodule

`default_nettype wire

// File: verification/mem_stage_assert.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage_assert (
    input logic                       clk,
    input logic                       rst_n_i,
    input logic                       ready_i,
    input logic                       valid_o,
    input logic [mem_pkg::DATA_W-1:0] op1_o,
    input logic [mem_pkg::DATA_W-1:0] op2_o,
    input logic [mem_pkg::DATA_W-1:0] op3_o,
    input logic [mem_pkg::DATA_W-1:0] op4_o,
    input logic [mem_pkg::ADDR_W-1:0] addr1_o,
    input logic [mem_pkg::ADDR_W-1:0] addr2_o,
    input logic                       psel_i,
    input logic                       penable_i,
    input logic                       pready_o,
    input logic                       pslverr_o
);
    int unsigned fail_cnt = 0;

    // reset clears the output stage and the apb response.
    a_reset: assert property (@(posedge clk) !rst_n_i |=> !valid_o && !pready_o && !pslverr_o)
        else begin
            $error("valid_o or apb response not cleared by reset");
            fail_cnt = fail_cnt + 1;
        end

    // a stalled beat stays put until it is taken.
    a_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        valid_o && !ready_i |=> valid_o && $stable(op1_o) && $stable(op2_o) && $stable(op3_o)
            && $stable(op4_o) && $stable(addr1_o) && $stable(addr2_o))
        else begin
            $error("held output beat changed or dropped under back-pressure");
            fail_cnt = fail_cnt + 1;
        end

    a_pready: assert property (@(posedge clk) disable iff (!rst_n_i)
        pready_o |-> psel_i && penable_i)
        else begin
            $error("pready_o high outside an APB access phase");
            fail_cnt = fail_cnt + 1;
        end

    // no wait states.
    a_no_wait: assert property (@(posedge clk) disable iff (!rst_n_i)
        psel_i && penable_i |-> pready_o)
        else begin
            $error("pready_o low in an APB access phase");
            fail_cnt = fail_cnt + 1;
        end

endmodule

bind mem_stage mem_stage_assert u_assert (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .ready_i   (ready_i),
    .valid_o   (valid_o),
    .op1_o     (op1_o),
    .op2_o     (op2_o),
    .op3_o     (op3_o),
    .op4_o     (op4_o),
    .addr1_o   (addr1_o),
    .addr2_o   (addr2_o),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o)
);

`default_nettype wire

// File: verification/mem_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage_tb;
    import mem_pkg::*;

    // the whole run needs about 400 cycles, so this leaves a wide margin.
    localparam int WATCHDOG_CYCLES = 4000;
    localparam int WAIT_LIMIT      = 40;

    logic                  clk = 1'b0;
    logic                  rst_n_i;
    logic                  valid_i;
    logic                  is_rep_i;
    logic                  dir_i;
    logic                  ready_i;
    logic [ADDR_W-1:0]     rep_cnt_i;
    logic [ADDR_W-1:0]     mem_addr1_i;
    logic [ADDR_W-1:0]     mem_addr2_i;
    logic [DATA_W-1:0]     reg1_i;
    logic [DATA_W-1:0]     reg2_i;
    logic [DATA_W-1:0]     reg3_i;
    logic [DATA_W-1:0]     reg4_i;
    logic [DATA_W-1:0]     imm_i;
    logic [DATA_W-1:0]     eip_i;
    op_src_e               op1_sel_i;
    op_src_e               op2_sel_i;
    op_src_e               op3_sel_i;
    op_src_e               op4_sel_i;
    logic                  psel_i;
    logic                  penable_i;
    logic                  pwrite_i;
    logic [APB_ADDR_W-1:0] paddr_i;
    logic [DATA_W-1:0]     pwdata_i;
    logic                  stall_o;
    logic                  valid_o;
    logic [DATA_W-1:0]     op1_o;
    logic [DATA_W-1:0]     op2_o;
    logic [DATA_W-1:0]     op3_o;
    logic [DATA_W-1:0]     op4_o;
    logic [ADDR_W-1:0]     addr1_o;
    logic [ADDR_W-1:0]     addr2_o;
    logic [DATA_W-1:0]     prdata_o;
    logic                  pready_o;
    logic                  pslverr_o;

    logic [DATA_W-1:0]   shadow [MEM_DEPTH];
    logic [31:0]         lcg_state = 32'd97;
    int                  cyc = 0;
    int                  errors = 0;
    int                  checks = 0;
    int                  mon_errors = 0;
    int                  next_got = 0;
    logic [6*DATA_W-1:0] exp_q [$];
    logic [6*DATA_W-1:0] got_q [$];
    int                  got_cyc [$];
    logic                held = 1'b0;
    logic [6*DATA_W-1:0] held_val;
    logic [6*DATA_W-1:0] out_now;
    string field_name [6] = '{"op1_o", "op2_o", "op3_o", "op4_o", "addr1_o", "addr2_o"};

    mem_stage dut0 (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    assign out_now = {addr2_o, addr1_o, op4_o, op3_o, op2_o, op1_o};

    // ########################################################################
    // output monitor, sampled mid-cycle.
    // ########################################################################

    always @(negedge clk) begin
        if (rst_n_i && held && (!valid_o || out_now != held_val)) begin
            mon_errors <= mon_errors + 1;
            $display("outputs changed while valid_o was held without ready_i, cycle %0d", cyc);
        end
        if (rst_n_i && valid_o && ready_i) begin
            got_q.push_back(out_now);
            got_cyc.push_back(cyc);
        end
        held     <= rst_n_i && valid_o && !ready_i;
        held_val <= out_now;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [DATA_W-1:0] pick_operand(input op_src_e sel,
                                                       input logic [DATA_W-1:0] m1,
                                                       input logic [DATA_W-1:0] m2);
        case (sel)
            SRC_REG1: return reg1_i;
            SRC_REG2: return reg2_i;
            SRC_REG3: return reg3_i;
            SRC_REG4: return reg4_i;
            SRC_MEM1: return m1;
            SRC_MEM2: return m2;
            SRC_IMM:  return imm_i;
            SRC_EIP:  return eip_i;
            default:  return '0;
        endcase
    endfunction

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    // each beat steps both addresses one word from the instruction's start.
    task automatic push_expected(input int beats);
        logic [ADDR_W-1:0] step;
        logic [ADDR_W-1:0] a1;
        logic [ADDR_W-1:0] a2;
        logic [DATA_W-1:0] m1;
        logic [DATA_W-1:0] m2;
        step = dir_i ? -32'd4 : 32'd4;
        for (int i = 0; i < beats; i++) begin
            a1 = mem_addr1_i + step * ADDR_W'(i);
            a2 = mem_addr2_i + step * ADDR_W'(i);
            m1 = shadow[a1[7:2]];
            m2 = shadow[a2[7:2]];
            exp_q.push_back({a2, a1, pick_operand(op4_sel_i, m1, m2),
                             pick_operand(op3_sel_i, m1, m2),
                             pick_operand(op2_sel_i, m1, m2),
                             pick_operand(op1_sel_i, m1, m2)});
        end
    endtask

    task automatic setup_instr(input logic rep, input logic dir, input logic [ADDR_W-1:0] cnt,
                               input op_src_e s1, input op_src_e s2,
                               input op_src_e s3, input op_src_e s4);
        is_rep_i    = rep;
        dir_i       = dir;
        rep_cnt_i   = cnt;
        mem_addr1_i = next_rand() & 32'hffff_fffc;
        mem_addr2_i = next_rand() & 32'hffff_fffc;
        reg1_i      = next_rand();
        reg2_i      = next_rand();
        reg3_i      = next_rand();
        reg4_i      = next_rand();
        imm_i       = next_rand();
        eip_i       = next_rand();
        op1_sel_i   = s1;
        op2_sel_i   = s2;
        op3_sel_i   = s3;
        op4_sel_i   = s4;
        push_expected(rep ? int'(cnt) : 1);
    endtask

    // holds the instruction until stall_o lets it go.
    task automatic send_instr(output int start, output int acc);
        int waited;
        waited  = 0;
        start   = cyc;
        valid_i = 1'b1;
        @(negedge clk);
        while (stall_o && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (stall_o) begin
            errors++;
            $display("stall_o never released the instruction issued at cycle %0d", start);
        end
        @(posedge clk);
        #2;
        valid_i = 1'b0;
        acc     = cyc;
    endtask

    task automatic wait_beats(input int total);
        int waited;
        waited = 0;
        while (got_q.size() < total && waited < WAIT_LIMIT) begin
            waited++;
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        #2;
        checks++;
        if (got_q.size() != total) begin
            errors++;
            $display("expected %0d output beats in total but saw %0d", total, got_q.size());
        end
    endtask

    task automatic compare_beats();
        logic [6*DATA_W-1:0] g;
        logic [6*DATA_W-1:0] e;
        for (int i = 0; i < exp_q.size() && next_got + i < got_q.size(); i++) begin
            e = exp_q[i];
            g = got_q[next_got + i];
            for (int f = 0; f < 6; f++) begin
                check_word(field_name[f], g[f*32 +: 32], e[f*32 +: 32]);
            end
        end
        next_got = got_q.size();
        exp_q.delete();
    endtask

    task automatic apb_access(input logic write, input logic [APB_ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] wdata,
                              output logic [DATA_W-1:0] rdata, output logic err);
        int waited;
        waited    = 0;
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = write;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(posedge clk);
        #2;
        penable_i = 1'b1;
        @(negedge clk);
        while (!pready_o && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (!pready_o) begin
            errors++;
            $display("pready_o never rose in the APB access phase at address %0d", addr);
        end
        rdata = prdata_o;
        err   = pslverr_o;
        @(posedge clk);
        #2;
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    // ########################################################################
    // directed tests.
    // ########################################################################

    task automatic test_apb();
        logic [DATA_W-1:0] rdata;
        logic              err;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            shadow[i] = next_rand();
            apb_access(1'b1, APB_ADDR_W'(i * 4), shadow[i], rdata, err);
            check_word("pslverr_o", 32'(err), 32'd0);
        end
        for (int i = 0; i < MEM_DEPTH; i++) begin
            apb_access(1'b0, APB_ADDR_W'(i * 4), '0, rdata, err);
            check_word("prdata_o", rdata, shadow[i]);
            check_word("pslverr_o", 32'(err), 32'd0);
        end
        // 276 would alias word 5 if the write were not dropped.
        apb_access(1'b1, 10'd276, 32'hdead_beef, rdata, err);
        check_word("pslverr_o", 32'(err), 32'd1);
        apb_access(1'b0, 10'd276, '0, rdata, err);
        check_word("prdata_o", rdata, 32'd0);
        check_word("pslverr_o", 32'(err), 32'd1);
        apb_access(1'b0, 10'd1020, '0, rdata, err);
        check_word("prdata_o", rdata, 32'd0);
        check_word("pslverr_o", 32'(err), 32'd1);
        apb_access(1'b0, 10'd20, '0, rdata, err);
        check_word("prdata_o", rdata, shadow[5]);
    endtask

    task automatic test_operand_select();
        int start;
        int acc;
        int first;
        int acc_q [$];
        first = next_got;
        for (int k = 0; k < 8; k++) begin
            setup_instr(1'b0, 1'b0, '0, op_src_e'(k), op_src_e'((k + 1) % 8),
                        op_src_e'((k + 2) % 8), op_src_e'((k + 5) % 8));
            send_instr(start, acc);
            check_word("stall_o release cycle", 32'(acc), 32'(start + 1));
            acc_q.push_back(acc);
        end
        wait_beats(first + 8);
        for (int k = 0; k < 8 && first + k < got_cyc.size(); k++) begin
            check_word("valid_o cycle", 32'(got_cyc[first + k]), 32'(acc_q[k]));
        end
        compare_beats();
    endtask

    task automatic test_rep(input logic dir, input int n);
        int start;
        int acc;
        int first;
        first = next_got;
        setup_instr(1'b1, dir, ADDR_W'(n), SRC_MEM1, SRC_MEM2, SRC_REG2, SRC_EIP);
        send_instr(start, acc);
        wait_beats(first + n);
        // stall_o drops in the cycle that issues the last beat.
        check_word("stall_o release cycle", 32'(acc), 32'(start + n));
        for (int i = 0; i < n && first + i < got_cyc.size(); i++) begin
            check_word("valid_o cycle", 32'(got_cyc[first + i]), 32'(start + 1 + i));
        end
        compare_beats();
    endtask

    task automatic test_backpressure(input logic dir, input int n, input int delay,
                                     input int len);
        int start;
        int acc;
        int first;
        first = next_got;
        setup_instr(1'b1, dir, ADDR_W'(n), SRC_MEM2, SRC_IMM, SRC_MEM1, SRC_REG4);
        fork
            send_instr(start, acc);
            begin
                repeat (delay) @(posedge clk);
                #2;
                ready_i = 1'b0;
                repeat (len) @(posedge clk);
                #2;
                ready_i = 1'b1;
            end
        join
        wait_beats(first + n);
        // stepping freezes for every cycle that ready_i is low.
        check_word("stall_o release cycle", 32'(acc), 32'(start + n + len));
        compare_beats();
    endtask

    task automatic test_rep_zero();
        int start;
        int acc;
        int first;
        first = next_got;
        setup_instr(1'b1, 1'b0, '0, SRC_MEM1, SRC_REG3, SRC_IMM, SRC_MEM2);
        send_instr(start, acc);
        check_word("stall_o release cycle", 32'(acc), 32'(start + 1));
        setup_instr(1'b0, 1'b0, '0, SRC_REG1, SRC_MEM1, SRC_IMM, SRC_REG4);
        send_instr(start, acc);
        wait_beats(first + 1);
        if (first < got_cyc.size()) begin
            check_word("valid_o cycle", 32'(got_cyc[first]), 32'(acc));
        end
        compare_beats();
    endtask

    initial begin
        rst_n_i     = 1'b0;
        valid_i     = 1'b0;
        is_rep_i    = 1'b0;
        dir_i       = 1'b0;
        ready_i     = 1'b1;
        rep_cnt_i   = '0;
        mem_addr1_i = '0;
        mem_addr2_i = '0;
        reg1_i      = '0;
        reg2_i      = '0;
        reg3_i      = '0;
        reg4_i      = '0;
        imm_i       = '0;
        eip_i       = '0;
        op1_sel_i   = SRC_REG1;
        op2_sel_i   = SRC_REG1;
        op3_sel_i   = SRC_REG1;
        op4_sel_i   = SRC_REG1;
        psel_i      = 1'b0;
        penable_i   = 1'b0;
        pwrite_i    = 1'b0;
        paddr_i     = '0;
        pwdata_i    = '0;
        repeat (5) @(posedge clk);
        #2;
        rst_n_i = 1'b1;
        check_word("valid_o", 32'(valid_o), 32'd0);
        check_word("stall_o", 32'(stall_o), 32'd0);
        check_word("pready_o", 32'(pready_o), 32'd0);
        check_word("pslverr_o", 32'(pslverr_o), 32'd0);
        test_apb();
        test_operand_select();
        test_rep(1'b0, 5);
        test_rep(1'b1, 6);
        test_rep(1'b0, 1);
        test_backpressure(1'b0, 8, 2, 5);
        test_backpressure(1'b1, 4, 1, 3);
        test_rep_zero();
        repeat (4) @(posedge clk);
        errors = errors + mon_errors + int'(dut0.u_assert.fail_cnt);
        $display("checks %0d, errors %0d, hold errors %0d, assertion failures %0d",
                 checks, errors, mon_errors, dut0.u_assert.fail_cnt);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
source/mem_pkg.sv
source/mem_agen.sv
source/mem_scratch.sv
source/op_lane.sv
source/mem_latch.sv
source/mem_stage.sv
verification/mem_stage_assert.sv
verification/mem_stage_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the memory stage testbench with verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module mem_stage_tb \
    -f tb.f \
    -Mdir obj_dir \
    -o mem_stage_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# assertion errors are counted by the testbench, so keep running past them.
sim_out=$(./obj_dir/mem_stage_sim +verilator+error+limit+100)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Simulation completed successfully"; then
    exit 0
fi

echo "pass message not found in simulator output"
exit 1
